// File: hdl/output_layer_pkg.sv
// Signed 16 bit fixed point with 10 fraction bits, no saturation, all arithmetic wraps
package output_layer_pkg;

	// Fixed-point format
	localparam int INT_BITS  = 5;                        // Integer bits above the binary point
	localparam int FRAC_BITS = 10;                       // Bits below the binary point
	localparam int FIX_WIDTH = 1 + INT_BITS + FRAC_BITS; // Sign bit in front

	// Activation, sigmoid-prime and delta word
	typedef logic signed [FIX_WIDTH-1:0] fix_t;

	// Full product of two fix_t words before rescaling
	typedef logic signed [2*FIX_WIDTH-1:0] fix_prod_t;

	// Value 1.0, used as the numeric form of a set ideal bit
	localparam fix_t FIX_ONE = fix_t'(1 << FRAC_BITS);

	// Values of the COST_TYPE parameter
	localparam int COST_QUAD = 0; // Quadratic cost, delta = (a - y) * sp
	localparam int COST_XENT = 1; // Cross-entropy cost, delta = a - y

	// Phase controller states
	// ST_FIRST covers the first sample after reset, nothing valid to read yet
	// ST_STEADY holds for good, the idle collection always has a full sample
	typedef enum logic {
		ST_FIRST  = 1'b0,
		ST_STEADY = 1'b1
	} ctrl_state_e;

endpackage

// File: hdl/ideal_output_delay.sv
// Fixed latency of CPC*(NUM_LAYERS-1) clocks, needs NUM_LAYERS of at least 2 and Z dividing P
module ideal_output_delay #(
	parameter int P          = 8, // Output neurons
	parameter int Z          = 2, // Lanes, one ideal bit each
	parameter int NUM_LAYERS = 3, // Layers the ideal bits travel past
	localparam int CHUNKS    = P / Z,
	localparam int CPC       = CHUNKS + 2,
	localparam int DEPTH     = CPC * (NUM_LAYERS - 1)
)(
	input  logic         clk,
	input  logic         rst_n_i,
	input  logic [Z-1:0] y_i,      // Ideal bits aligned with the input layer
	output logic [Z-1:0] y_late_o  // Ideal bits aligned with the output layer
);

	// One stage per clock of the earlier layers
	logic [Z-1:0] stage_q [DEPTH];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stage_q <= '{default: '0}; // Zeros until real ideal bits arrive
		end else begin
			stage_q[0] <= y_i;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1]; // Plain shift without enable
			end
		end
	end

	// Tail of the line
	assign y_late_o = stage_q[DEPTH-1];

endmodule

// File: hdl/cost_lane.sv
// Purely combinational, quadratic product truncates towards minus infinity and wraps
module cost_lane #(
	parameter int COST_TYPE = output_layer_pkg::COST_XENT // COST_XENT or COST_QUAD
)(
	input  output_layer_pkg::fix_t act_i,  // Activation of this neuron
	input  output_layer_pkg::fix_t sp_i,   // Sigmoid-prime, used by quadratic cost only
	input  logic                   y_i,    // Ideal output bit
	output output_layer_pkg::fix_t delta_o // Output-layer delta
);

	output_layer_pkg::fix_t y_fix;     // Ideal bit as 1.0 or 0.0
	output_layer_pkg::fix_t a_minus_y; // Cost term, wraps on overflow

	assign y_fix     = y_i ? output_layer_pkg::FIX_ONE : '0;
	assign a_minus_y = act_i - y_fix;

	if (COST_TYPE == output_layer_pkg::COST_QUAD) begin : g_quad
		output_layer_pkg::fix_prod_t prod;     // Full signed product
		output_layer_pkg::fix_prod_t prod_scl; // Back to FRAC_BITS fraction bits

		// Both operands signed, so they sign extend to the product width
		assign prod = a_minus_y * sp_i;

		// Arithmetic shift keeps the sign, floor rounding
		assign prod_scl = prod >>> output_layer_pkg::FRAC_BITS;

		// Low word only, upper bits dropped
		assign delta_o = output_layer_pkg::fix_t'(prod_scl);
	end else begin : g_xent
		// Sigmoid-prime cancels against the cost derivative
		assign delta_o = a_minus_y;
	end

endmodule

// File: hdl/delta_phase_ctrl.sv
// cycle_index_i must count 0 to CPC-1 from the first clock after reset and wrap without gaps
module delta_phase_ctrl #(
	parameter int P       = 8, // Output neurons
	parameter int Z       = 2, // Lanes
	localparam int CHUNKS = P / Z,
	localparam int CPC    = CHUNKS + 2,
	localparam int IDX_W  = $clog2(CPC)
)(
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic [IDX_W-1:0] cycle_index_i, // Phase within the sample period
	output logic             wr_en_o,       // Write the lane deltas this clock
	output logic [IDX_W-1:0] wr_addr_o,     // Chunk being written
	output logic             wr_coll_o,     // Collection being written
	output logic [IDX_W-1:0] rd_addr_o,     // Chunk being read from the other collection
	output logic             delta_valid_o  // Bank output holds a previous-sample chunk
);

	localparam logic [IDX_W-1:0] LAST_IDX  = IDX_W'(CPC - 1); // Last clock of a sample
	localparam logic [IDX_W-1:0] CHUNK_END = IDX_W'(CHUNKS);  // First index past the chunks

	output_layer_pkg::ctrl_state_e state_q;
	output_layer_pkg::ctrl_state_e state_d;

	logic wrap;     // Sample ends at this clock edge
	logic in_chunk; // Index addresses a chunk
	logic coll_q;   // Write collection pointer
	logic valid_q;  // Read phase one clock late to match the memory register

	assign wrap     = (cycle_index_i == LAST_IDX);
	assign in_chunk = (cycle_index_i < CHUNK_END);

	// Only the first sample needs special treatment
	always_comb begin
		state_d = state_q;
		case (state_q)
			output_layer_pkg::ST_FIRST: begin
				if (wrap) begin
					state_d = output_layer_pkg::ST_STEADY; // First sample fully written
				end
			end
			output_layer_pkg::ST_STEADY: state_d = output_layer_pkg::ST_STEADY;
			default: state_d = output_layer_pkg::ST_FIRST;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= output_layer_pkg::ST_FIRST;
			coll_q  <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			coll_q  <= coll_q ^ wrap; // Ping-pong swap at every sample boundary
			valid_q <= (state_q == output_layer_pkg::ST_STEADY) && in_chunk;
		end
	end

	assign wr_en_o       = in_chunk;      // Lanes deliver chunk k at index k
	assign wr_addr_o     = cycle_index_i;
	assign wr_coll_o     = coll_q;
	assign rd_addr_o     = cycle_index_i; // Read runs in lockstep with the write
	assign delta_valid_o = valid_q;

	// Phase input stays inside one sample period
	a_idx_range: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		int'(cycle_index_i) < CPC
	);

	// Phase counts up by one and wraps after CPC-1, starting at the first clock out of reset
	a_idx_step: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		rst_n_i |=> (cycle_index_i == ($past(wrap) ? '0 : $past(cycle_index_i) + 1'b1))
	);

endmodule

// File: hdl/delta_mem_bank.sv
// Two collections of Z memories CHUNKS deep where the read always targets the idle collection
module delta_mem_bank #(
	parameter int P       = 8, // Output neurons
	parameter int Z       = 2, // Lanes, one memory per lane and collection
	localparam int CHUNKS = P / Z,
	localparam int CPC    = CHUNKS + 2,
	localparam int IDX_W  = $clog2(CPC),
	localparam int ADDR_W = (CHUNKS > 1) ? $clog2(CHUNKS) : 1
)(
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  logic                            wr_en_i,   // Store delta_i this clock
	input  logic [IDX_W-1:0]                wr_addr_i, // Chunk index of delta_i
	input  logic                            wr_coll_i, // Collection being filled
	input  logic [IDX_W-1:0]                rd_addr_i, // Chunk index to read
	input  output_layer_pkg::fix_t [Z-1:0]  delta_i,   // Fresh deltas from the lanes
	output output_layer_pkg::fix_t [Z-1:0]  delta_o    // Previous-sample deltas
);

	localparam logic [IDX_W-1:0] CHUNK_END = IDX_W'(CHUNKS);

	// Collection, lane, chunk
	output_layer_pkg::fix_t mem [2][Z][CHUNKS];

	logic              rd_coll; // Collection being drained
	logic              rd_hit;  // Read index addresses a chunk
	logic [ADDR_W-1:0] wr_row;
	logic [ADDR_W-1:0] rd_row;

	assign rd_coll = ~wr_coll_i;
	assign rd_hit  = (rd_addr_i < CHUNK_END);
	assign wr_row  = wr_addr_i[ADDR_W-1:0]; // Upper index bits are zero while writing
	assign rd_row  = rd_addr_i[ADDR_W-1:0];

	// All lanes write at the same address and collection
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			for (int j = 0; j < Z; j++) begin
				mem[wr_coll_i][j][wr_row] <= delta_i[j];
			end
		end
	end

	// Registered read that holds the last chunk outside the read phase
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			delta_o <= '0;
		end else if (rd_hit) begin
			for (int j = 0; j < Z; j++) begin
				delta_o[j] <= mem[rd_coll][j][rd_row];
			end
		end
	end

	// All chunks of one sample land in one collection
	a_coll_hold: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		(wr_en_i && $past(wr_en_i)) |-> $stable(wr_coll_i)
	);

endmodule

// File: hdl/output_layer.sv
// Z must divide P, deltas of sample s come out in sample s+1, no back-pressure on any output
module output_layer #(
	parameter int P          = 8,                            // Output neurons
	parameter int Z          = 2,                            // Lanes per clock
	parameter int NUM_LAYERS = 3,                            // Layers in the network
	parameter int COST_TYPE  = output_layer_pkg::COST_XENT, // COST_XENT or COST_QUAD
	localparam int CHUNKS    = P / Z,
	localparam int CPC       = CHUNKS + 2,
	localparam int IDX_W     = $clog2(CPC)
)(
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic [IDX_W-1:0]               cycle_index_i, // Sample phase, 0 to CPC-1
	input  output_layer_pkg::fix_t [Z-1:0] act_i,         // Chunk of activations
	input  output_layer_pkg::fix_t [Z-1:0] sp_i,          // Matching sigmoid-prime values
	input  logic [Z-1:0]                   y_i,           // Ideal bits at the input layer
	output output_layer_pkg::fix_t [Z-1:0] delta_o,       // Previous-sample deltas
	output logic                           delta_valid_o, // delta_o carries a chunk
	output logic [Z-1:0]                   yl_o           // Ideal bits at the output layer
);

	output_layer_pkg::fix_t [Z-1:0] lane_delta; // Fresh deltas, one per lane

	logic             wr_en;
	logic [IDX_W-1:0] wr_addr;
	logic             wr_coll;
	logic [IDX_W-1:0] rd_addr;

	// Ideal bits catch up with their activations
	ideal_output_delay #(
		.P          (P),
		.Z          (Z),
		.NUM_LAYERS (NUM_LAYERS)
	) u_ideal_delay (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.y_i      (y_i),
		.y_late_o (yl_o)
	);

	// One lane per neuron of the current chunk
	for (genvar j = 0; j < Z; j++) begin : g_lane
		cost_lane #(
			.COST_TYPE (COST_TYPE)
		) u_cost_lane (
			.act_i   (act_i[j]),
			.sp_i    (sp_i[j]),
			.y_i     (yl_o[j]),
			.delta_o (lane_delta[j])
		);
	end

	// Phase decode and ping-pong pointer
	delta_phase_ctrl #(
		.P (P),
		.Z (Z)
	) u_phase_ctrl (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cycle_index_i (cycle_index_i),
		.wr_en_o       (wr_en),
		.wr_addr_o     (wr_addr),
		.wr_coll_o     (wr_coll),
		.rd_addr_o     (rd_addr),
		.delta_valid_o (delta_valid_o)
	);

	// Delta storage towards the earlier layer
	delta_mem_bank #(
		.P (P),
		.Z (Z)
	) u_mem_bank (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_coll_i (wr_coll),
		.rd_addr_i (rd_addr),
		.delta_i   (lane_delta),
		.delta_o   (delta_o)
	);

endmodule

// File: dv/output_layer_tb.sv
// Runs P=8 Z=2 with three layers, COST_TYPE is overridden per run, stimulus keeps the product in range
module output_layer_tb #(
	parameter int COST_TYPE = output_layer_pkg::COST_XENT // Overridden for the quadratic run
);

	localparam int P          = 8;
	localparam int Z          = 2;
	localparam int NUM_LAYERS = 3;
	localparam int CHUNKS     = P / Z;
	localparam int CPC        = CHUNKS + 2;            // Clocks per sample
	localparam int IDX_W      = $clog2(CPC);
	localparam int DEPTH      = CPC * (NUM_LAYERS - 1); // Ideal bit latency

	logic                           clk = 1'b0;
	logic                           rst_n_i;
	logic [IDX_W-1:0]               cycle_index_i;
	output_layer_pkg::fix_t [Z-1:0] act_i;
	output_layer_pkg::fix_t [Z-1:0] sp_i;
	logic [Z-1:0]                   y_i;
	output_layer_pkg::fix_t [Z-1:0] delta_o;
	logic                           delta_valid_o;
	logic [Z-1:0]                   yl_o;

	logic [15:0] lfsr_q = 16'd53;   // Stimulus generator state
	int          errors = 0;
	int          checks = 0;
	bit          timeout_seen = 1'b0;

	// Reference model state
	output_layer_pkg::fix_t sb [2][P];            // Expected deltas, one buffer per sample parity
	logic                   par = 1'b0;           // Buffer of the sample being written
	bit                     steady = 1'b0;        // A full sample is already stored
	bit                     exp_valid = 1'b0;
	output_layer_pkg::fix_t exp_delta [Z];
	logic [Z-1:0]           y_hist [$];           // y_i history, front is the expected yl_o

	output_layer #(
		.P          (P),
		.Z          (Z),
		.NUM_LAYERS (NUM_LAYERS),
		.COST_TYPE  (COST_TYPE)
	) u_output_layer (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cycle_index_i (cycle_index_i),
		.act_i         (act_i),
		.sp_i          (sp_i),
		.y_i           (y_i),
		.delta_o       (delta_o),
		.delta_valid_o (delta_valid_o),
		.yl_o          (yl_o)
	);

	always #50 clk = ~clk; // 100 unit period

	// x^16 + x^14 + x^13 + x^11 + 1, shifts right
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[0] ^ s[2] ^ s[3] ^ s[5];
		return {fb, s[15:1]};
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v      = {v[14:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// Expected delta from the cost rule, wide integer math then truncated
	function automatic output_layer_pkg::fix_t ref_delta(
		input output_layer_pkg::fix_t a,
		input output_layer_pkg::fix_t sp,
		input logic                   y
	);
		longint diff;
		longint prod;
		diff = longint'(a) - (y ? longint'(output_layer_pkg::FIX_ONE) : 64'sd0);
		prod = diff * longint'(sp);
		if (COST_TYPE == output_layer_pkg::COST_QUAD) begin
			return output_layer_pkg::fix_t'(prod >>> output_layer_pkg::FRAC_BITS); // Floor
		end else begin
			return output_layer_pkg::fix_t'(diff);
		end
	endfunction

	task automatic compare_value(
		input logic signed [31:0] got,
		input logic signed [31:0] exp,
		input string              what
	);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t: %s, got %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// Model back to its post-reset view
	task automatic restart_model();
		steady    = 1'b0;
		par       = 1'b0;
		exp_valid = 1'b0;
		for (int j = 0; j < Z; j++) begin
			exp_delta[j] = '0;
		end
		y_hist.delete();
		repeat (DEPTH) y_hist.push_back('0); // Delay line starts cleared
	endtask

	// Phase counter and random data, all on the rising edge
	always @(posedge clk) begin : drive_inputs
		logic [15:0] r;
		if (!rst_n_i || cycle_index_i == IDX_W'(CPC - 1)) begin
			cycle_index_i <= '0; // Index 0 in the first clock out of reset
		end else begin
			cycle_index_i <= cycle_index_i + 1'b1;
		end
		for (int j = 0; j < Z; j++) begin
			take_bits(10, r);
			act_i[j] <= output_layer_pkg::fix_t'(r); // 0 to just under 1.0
			take_bits(8, r);
			sp_i[j] <= output_layer_pkg::fix_t'(r);  // Below a quarter
			take_bits(1, r);
			y_i[j] <= r[0];
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin : compare_outputs
		int           idx;
		logic [Z-1:0] yl_exp;
		if (!rst_n_i) begin
			compare_value(delta_valid_o, 0, "delta_valid_o in reset");
			compare_value(yl_o, 0, "yl_o in reset");
			for (int j = 0; j < Z; j++) begin
				compare_value(delta_o[j], 0, $sformatf("delta_o lane %0d in reset", j));
			end
			restart_model();
		end else begin
			yl_exp = y_hist[0];
			compare_value(delta_valid_o, exp_valid, "delta_valid_o");
			compare_value(yl_o, yl_exp, "yl_o");
			if (exp_valid) begin
				for (int j = 0; j < Z; j++) begin
					compare_value(delta_o[j], exp_delta[j], $sformatf("delta_o lane %0d", j));
				end
			end
			idx = int'(cycle_index_i);
			if (idx < CHUNKS) begin
				for (int j = 0; j < Z; j++) begin
					exp_delta[j]         = sb[par ^ 1'b1][idx*Z+j]; // Previous sample only
					sb[par][idx*Z+j] = ref_delta(act_i[j], sp_i[j], yl_exp[j]);
				end
			end
			exp_valid = steady && (idx < CHUNKS); // Shows one clock later
			if (idx == CPC - 1) begin
				steady = 1'b1;
				par    = par ^ 1'b1; // Sample boundary
			end
			void'(y_hist.pop_front());
			y_hist.push_back(y_i);
		end
	end

	// Called right after a rising edge
	task automatic apply_reset(input int n);
		rst_n_i <= 1'b0;
		repeat (n) @(posedge clk);
		rst_n_i <= 1'b1;
	endtask

	// First valid must show CPC+1 clocks after release
	task automatic measure_valid_latency();
		int cnt;
		bit seen;
		cnt  = 0;
		seen = 1'b0;
		while (!seen && cnt <= 4 * CPC) begin
			@(negedge clk);
			if (delta_valid_o === 1'b1) seen = 1'b1;
			else cnt++;
		end
		if (!seen) begin
			$display("Timeout: delta_valid_o never went high after reset release");
			timeout_seen = 1'b1;
		end else begin
			compare_value(cnt, CPC + 1, "clocks from reset release to first delta_valid_o");
		end
	endtask

	// Returns at the rising edge that ends index k
	task automatic wait_index(input int k);
		int n;
		bit hit;
		n   = 0;
		hit = 1'b0;
		while (!hit && n < 4 * CPC) begin
			@(posedge clk);
			hit = (int'(cycle_index_i) == k);
			n++;
		end
		if (!hit) begin
			$display("Timeout: cycle index never reached %0d", k);
			timeout_seen = 1'b1;
		end
	endtask

	task automatic run_clocks(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic finish_report();
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeout_seen);
		if (errors == 0 && !timeout_seen) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	initial begin
		rst_n_i       = 1'b0;
		cycle_index_i = '0;
		act_i         = '0;
		sp_i          = '0;
		y_i           = '0;
		apply_reset(10);
		measure_valid_latency();
		if (!timeout_seen) run_clocks(40 * CPC); // Long ping-pong stretch
		if (!timeout_seen) wait_index(2);        // Reset in the middle of a sample
		if (!timeout_seen) begin
			apply_reset(3);
			measure_valid_latency();
		end
		if (!timeout_seen) run_clocks(20 * CPC);
		finish_report();
	end

endmodule

// File: output_layer.f
hdl/output_layer_pkg.sv
hdl/ideal_output_delay.sv
hdl/cost_lane.sv
hdl/delta_phase_ctrl.sv
hdl/delta_mem_bank.sv
hdl/output_layer.sv
dv/output_layer_tb.sv

// File: Bender.yml
package:
  name: output_layer

sources:
  # Package first, then leaf modules, then the top level
  - hdl/output_layer_pkg.sv
  - hdl/ideal_output_delay.sv
  - hdl/cost_lane.sv
  - hdl/delta_phase_ctrl.sv
  - hdl/delta_mem_bank.sv
  - hdl/output_layer.sv

  # Testbench, top module output_layer_tb
  - target: simulation
    files:
      - dv/output_layer_tb.sv
